// File: design/tsvid_pkg.sv
package tsvid_pkg;

	// raster timing, one pixel per clock
	localparam int H_TOTAL   = 64;
	localparam int V_TOTAL   = 40;
	localparam int H_SYNC    = 6;
	localparam int V_SYNC    = 2;
	localparam int H_ACT_BEG = 16;
	localparam int H_ACT_LEN = 32;
	localparam int V_ACT_BEG = 8;
	localparam int V_ACT_LEN = 16;

	// 4 pixels per 16-bit word
	localparam int WORDS_PER_LINE = 8;
	localparam int DRAM_CREDITS   = 4;
	localparam int PIPE_LAT       = 2;

	// port map
	localparam logic [7:0] REG_VPAGE    = 8'h01;
	localparam logic [7:0] REG_GY_OFFS  = 8'h04;
	localparam logic [7:0] REG_PALSEL   = 8'h07;
	localparam logic [7:0] REG_BORDER   = 8'h0F;
	localparam logic [7:0] REG_VINT_BEG = 8'h23;

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
	} port_wr_t;

	// data is 5:5:5 red, green, blue
	typedef struct packed {
		logic [7:0]  addr;
		logic [14:0] data;
	} cram_wr_t;

	typedef struct packed {
		logic [7:0] border;
		logic [7:0] vpage;
		logic [7:0] gy_offs;
		logic [7:0] palsel;
		logic [5:0] vint_beg;
	} vid_cfg_t;

	typedef struct packed {
		logic [5:0] hcount;
		logic [5:0] vcount;
		logic       hsync;
		logic       vsync;
		logic       active;
		logic       line_start;
		logic       frame_start;
	} raster_t;

	typedef struct packed {
		logic [20:0] addr;
	} dram_rd_t;

	typedef struct packed {
		logic [15:0] data;
	} dram_resp_t;

	typedef struct packed {
		logic [1:0] red;
		logic [1:0] grn;
		logic [1:0] blu;
	} rgb_t;

endpackage

// File: design/video_ports.sv
`timescale 1ns/100ps

module video_ports (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 port_we,
	input  tsvid_pkg::port_wr_t  port_wr,
	input  tsvid_pkg::raster_t   ras,
	output tsvid_pkg::vid_cfg_t  cfg
);

	// live registers, written by the CPU
	logic [7:0] border;
	logic [7:0] vpage;
	logic [7:0] gy_offs;
	logic [7:0] palsel;
	logic [5:0] vint_beg;

	// frame-latched copies
	logic [7:0] vpage_sh;
	logic [7:0] palsel_sh;

	always_ff @(posedge clk) begin
		if (rst) begin
			border    <= '0;
			vpage     <= '0;
			gy_offs   <= '0;
			palsel    <= '0;
			vint_beg  <= '0;
			vpage_sh  <= '0;
			palsel_sh <= '0;
		end else begin
			if (port_we) begin
				case (port_wr.addr)
					tsvid_pkg::REG_BORDER:   border   <= port_wr.data;
					tsvid_pkg::REG_VPAGE:    vpage    <= port_wr.data;
					tsvid_pkg::REG_GY_OFFS:  gy_offs  <= port_wr.data;
					tsvid_pkg::REG_PALSEL:   palsel   <= port_wr.data;
					tsvid_pkg::REG_VINT_BEG: vint_beg <= port_wr.data[5:0];
					default: ;
				endcase
			end
			// page and palette switch only between frames
			if (ras.frame_start) begin
				vpage_sh  <= vpage;
				palsel_sh <= palsel;
			end
		end
	end

	always_comb begin
		cfg.border   = border;
		cfg.vpage    = vpage_sh;
		cfg.gy_offs  = gy_offs;
		cfg.palsel   = palsel_sh;
		cfg.vint_beg = vint_beg;
	end

endmodule

// File: design/video_sync.sv
`timescale 1ns/100ps

module video_sync (
	input  logic                clk,
	input  logic                rst,
	input  tsvid_pkg::vid_cfg_t cfg,
	output tsvid_pkg::raster_t  ras,
	output logic                int_start
);

	logic [5:0] hcount;
	logic [5:0] vcount;
	logic [5:0] vcount_next;
	logic       h_last;
	logic       v_last;
	logic       hact;
	logic       vact;

	assign h_last = hcount == 6'(tsvid_pkg::H_TOTAL - 1);
	assign v_last = vcount == 6'(tsvid_pkg::V_TOTAL - 1);

	// line number seen after the next line wrap
	assign vcount_next = v_last ? 6'd0 : vcount + 6'd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			hcount <= h_last ? 6'd0 : hcount + 6'd1;
			if (h_last)
				vcount <= vcount_next;
		end
	end

	// registered so it lands exactly on hcount 0 of the chosen line
	always_ff @(posedge clk) begin
		if (rst)
			int_start <= 1'b0;
		else
			int_start <= h_last && (vcount_next == cfg.vint_beg);
	end

	assign hact = (hcount >= 6'(tsvid_pkg::H_ACT_BEG)) &&
		(hcount < 6'(tsvid_pkg::H_ACT_BEG + tsvid_pkg::H_ACT_LEN));
	assign vact = (vcount >= 6'(tsvid_pkg::V_ACT_BEG)) &&
		(vcount < 6'(tsvid_pkg::V_ACT_BEG + tsvid_pkg::V_ACT_LEN));

	always_comb begin
		ras.hcount      = hcount;
		ras.vcount      = vcount;
		ras.hsync       = hcount < 6'(tsvid_pkg::H_SYNC);
		ras.vsync       = vcount < 6'(tsvid_pkg::V_SYNC);
		ras.active      = hact && vact;
		ras.line_start  = hcount == 6'd0;
		ras.frame_start = (hcount == 6'd0) && (vcount == 6'd0);
	end

endmodule

// File: design/video_fetch.sv
`timescale 1ns/100ps

module video_fetch (
	input  logic                  clk,
	input  logic                  rst,
	input  tsvid_pkg::vid_cfg_t   cfg,
	input  tsvid_pkg::raster_t    ras,
	output logic                  dram_req_valid,
	output tsvid_pkg::dram_rd_t   dram_req,
	input  logic                  dram_resp_valid,
	input  tsvid_pkg::dram_resp_t dram_resp,
	input  logic                  dram_credit,
	input  logic [2:0]            rd_idx,
	output logic [15:0]           rd_word
);

	// two line halves of WORDS_PER_LINE words each
	logic [15:0] line_mem [0:15];
	logic        rd_half;
	logic [2:0]  wr_idx;
	logic [3:0]  req_cnt;
	logic [2:0]  credits;
	logic [7:0]  page;
	logic [7:0]  row_base;
	logic [5:0]  next_row;
	logic        fetch_go;
	logic        issue;

	assign next_row = ras.vcount + 6'd1 - 6'(tsvid_pkg::V_ACT_BEG);

	// last fetch is on the line before the last active one
	assign fetch_go = ras.line_start &&
		(ras.vcount >= 6'(tsvid_pkg::V_ACT_BEG - 1)) &&
		(ras.vcount < 6'(tsvid_pkg::V_ACT_BEG + tsvid_pkg::V_ACT_LEN - 1));

	assign issue = (req_cnt != 4'(tsvid_pkg::WORDS_PER_LINE)) && (credits != 3'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			credits        <= 3'(tsvid_pkg::DRAM_CREDITS);
			req_cnt        <= 4'(tsvid_pkg::WORDS_PER_LINE);
			dram_req_valid <= 1'b0;
		end else begin
			credits        <= credits - {2'b00, issue} + {2'b00, dram_credit};
			dram_req_valid <= issue;
			if (fetch_go)
				req_cnt <= '0;
			else if (issue)
				req_cnt <= req_cnt + 4'd1;
		end
	end

	// page and row are frozen for the whole line fetch
	always_ff @(posedge clk) begin
		if (fetch_go) begin
			page     <= cfg.vpage;
			row_base <= {2'b00, next_row} + cfg.gy_offs;
		end
		if (issue)
			dram_req.addr <= {2'b00, page, row_base, req_cnt[2:0]};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_half <= 1'b0;
			wr_idx  <= '0;
		end else begin
			if (ras.line_start)
				rd_half <= ~rd_half;
			if (fetch_go)
				wr_idx <= '0;
			else if (dram_resp_valid)
				wr_idx <= wr_idx + 3'd1;
		end
	end

	// responses arrive in order, fill the idle half
	always_ff @(posedge clk) begin
		if (dram_resp_valid)
			line_mem[{~rd_half, wr_idx}] <= dram_resp.data;
	end

	assign rd_word = line_mem[{rd_half, rd_idx}];

endmodule

// File: design/video_render.sv
`timescale 1ns/100ps

module video_render (
	input  logic                clk,
	input  logic                rst,
	input  tsvid_pkg::vid_cfg_t cfg,
	input  tsvid_pkg::raster_t  ras,
	output logic [2:0]          rd_idx,
	input  logic [15:0]         rd_word,
	input  logic                cram_we,
	input  tsvid_pkg::cram_wr_t cram_wr,
	output tsvid_pkg::rgb_t     rgb,
	output logic                hsync_out,
	output logic                vsync_out
);

	logic [14:0] cram [0:255];
	logic [4:0]  px;
	logic [3:0]  nib;
	logic [7:0]  pal_idx;
	logic [7:0]  idx_q;
	logic        blank_q;
	logic        hs_q;
	logic        vs_q;
	logic [14:0] ent;

	// pixel position inside the active window
	assign px      = 5'(ras.hcount - 6'(tsvid_pkg::H_ACT_BEG));
	assign rd_idx  = px[4:2];
	assign nib     = rd_word[{px[1:0], 2'b00} +: 4];
	assign pal_idx = ras.active ? {cfg.palsel[3:0], nib} : cfg.border;

	always_ff @(posedge clk) begin
		if (cram_we)
			cram[cram_wr.addr] <= cram_wr.data;
	end

	always_ff @(posedge clk)
		idx_q <= pal_idx;

	// stage 1 flags
	always_ff @(posedge clk) begin
		if (rst) begin
			blank_q <= 1'b1;
			hs_q    <= 1'b0;
			vs_q    <= 1'b0;
		end else begin
			blank_q <= ras.hsync | ras.vsync;
			hs_q    <= ras.hsync;
			vs_q    <= ras.vsync;
		end
	end

	assign ent = cram[idx_q];

	// stage 2, top two bits of each 5-bit channel
	always_ff @(posedge clk) begin
		if (rst) begin
			rgb       <= '0;
			hsync_out <= 1'b0;
			vsync_out <= 1'b0;
		end else begin
			rgb       <= blank_q ? '0 : {ent[14:13], ent[9:8], ent[4:3]};
			hsync_out <= hs_q;
			vsync_out <= vs_q;
		end
	end

endmodule

// File: design/video_top.sv
`timescale 1ns/100ps

module video_top (
	input  logic                  clk,
	input  logic                  rst,

	// CPU side
	input  logic                  port_we,
	input  tsvid_pkg::port_wr_t   port_wr,
	input  logic                  cram_we,
	input  tsvid_pkg::cram_wr_t   cram_wr,

	// video out
	output tsvid_pkg::rgb_t       rgb,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  int_start,

	// DRAM, credit flow control
	output logic                  dram_req_valid,
	output tsvid_pkg::dram_rd_t   dram_req,
	input  logic                  dram_resp_valid,
	input  tsvid_pkg::dram_resp_t dram_resp,
	input  logic                  dram_credit
);

	tsvid_pkg::vid_cfg_t cfg;
	tsvid_pkg::raster_t  ras;
	logic [2:0]          rd_idx;
	logic [15:0]         rd_word;

	video_ports video_ports (
		.clk         (clk),
		.rst         (rst),
		.port_we     (port_we),
		.port_wr     (port_wr),
		.ras         (ras),
		.cfg         (cfg)
	);

	video_sync video_sync (
		.clk         (clk),
		.rst         (rst),
		.cfg         (cfg),
		.ras         (ras),
		.int_start   (int_start)
	);

	video_fetch video_fetch (
		.clk             (clk),
		.rst             (rst),
		.cfg             (cfg),
		.ras             (ras),
		.dram_req_valid  (dram_req_valid),
		.dram_req        (dram_req),
		.dram_resp_valid (dram_resp_valid),
		.dram_resp       (dram_resp),
		.dram_credit     (dram_credit),
		.rd_idx          (rd_idx),
		.rd_word         (rd_word)
	);

	video_render video_render (
		.clk         (clk),
		.rst         (rst),
		.cfg         (cfg),
		.ras         (ras),
		.rd_idx      (rd_idx),
		.rd_word     (rd_word),
		.cram_we     (cram_we),
		.cram_wr     (cram_wr),
		.rgb         (rgb),
		.hsync_out   (hsync),
		.vsync_out   (vsync)
	);

endmodule

// File: tests/tb_video_top.sv
`timescale 1ns/100ps

module tb_video_top;

	localparam int N_TESTS = 4;
	localparam int FRAME   = tsvid_pkg::H_TOTAL * tsvid_pkg::V_TOTAL;
	localparam int REQS    = tsvid_pkg::WORDS_PER_LINE * tsvid_pkg::V_ACT_LEN;
	localparam int LIMIT   = (N_TESTS + 2) * FRAME + 100;
	// page and palette writes land mid-frame, inside the active area
	localparam int WR_POS  = 20 * tsvid_pkg::H_TOTAL + 30;

	logic                  clk;
	logic                  rst;
	logic                  port_we;
	tsvid_pkg::port_wr_t   port_wr;
	logic                  cram_we;
	tsvid_pkg::cram_wr_t   cram_wr;
	tsvid_pkg::rgb_t       rgb;
	logic                  hsync;
	logic                  vsync;
	logic                  int_start;
	logic                  dram_req_valid;
	tsvid_pkg::dram_rd_t   dram_req;
	logic                  dram_resp_valid;
	tsvid_pkg::dram_resp_t dram_resp;
	logic                  dram_credit;

	tsvid_pkg::vid_cfg_t   tests [0:N_TESTS-1];
	int                    err_cnt;
	int                    err_mark;
	int                    fails;
	int                    req_total;
	int                    pulses;
	int                    t;
	int                    cycles;
	int                    mcyc;
	int                    lat;
	logic [31:0]           lfsr;
	logic [20:0]           q_addr [$];
	int                    q_due [$];
	logic [20:0]           rsp_addr;

	video_top video_top_i (
		.clk             (clk),
		.rst             (rst),
		.port_we         (port_we),
		.port_wr         (port_wr),
		.cram_we         (cram_we),
		.cram_wr         (cram_wr),
		.rgb             (rgb),
		.hsync           (hsync),
		.vsync           (vsync),
		.int_start       (int_start),
		.dram_req_valid  (dram_req_valid),
		.dram_req        (dram_req),
		.dram_resp_valid (dram_resp_valid),
		.dram_resp       (dram_resp),
		.dram_credit     (dram_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// palette contents, a fixed scramble of the index
	function automatic logic [14:0] pal_entry(input logic [7:0] i);
		return {i[7:6] ^ i[1:0], i[2:0], i[5:4] ^ i[3:2], i[7:5],
			i[1:0] ^ i[3:2] ^ i[7:6], ~i[2:0]};
	endfunction

	function automatic tsvid_pkg::rgb_t colour_of(input logic [7:0] idx);
		logic [14:0] c;
		c = pal_entry(idx);
		return {c[14:13], c[9:8], c[4:3]};
	endfunction

	// frame 0 runs on the reset values
	function automatic tsvid_pkg::vid_cfg_t cfg_of(input int frame);
		if (frame >= 1 && frame <= N_TESTS)
			return tests[frame - 1];
		return '0;
	endfunction

	function automatic tsvid_pkg::dram_rd_t addr_of(input int frame, input int row, input int word);
		tsvid_pkg::vid_cfg_t c;
		logic [7:0]          line;
		c    = cfg_of(frame);
		line = 8'(row) + c.gy_offs;
		return {2'b00, c.vpage, line, 3'(word)};
	endfunction

	function automatic tsvid_pkg::rgb_t pixel_of(input int p);
		tsvid_pkg::vid_cfg_t c;
		tsvid_pkg::dram_rd_t a;
		logic [15:0]         data;
		int                  h;
		int                  v;
		int                  x;
		c = cfg_of(p / FRAME);
		h = p % tsvid_pkg::H_TOTAL;
		v = (p / tsvid_pkg::H_TOTAL) % tsvid_pkg::V_TOTAL;
		if (h < tsvid_pkg::H_SYNC || v < tsvid_pkg::V_SYNC)
			return '0;
		if (h >= tsvid_pkg::H_ACT_BEG && h < tsvid_pkg::H_ACT_BEG + tsvid_pkg::H_ACT_LEN &&
			v >= tsvid_pkg::V_ACT_BEG && v < tsvid_pkg::V_ACT_BEG + tsvid_pkg::V_ACT_LEN) begin
			x    = h - tsvid_pkg::H_ACT_BEG;
			a    = addr_of(p / FRAME, v - tsvid_pkg::V_ACT_BEG, x / 4);
			data = a.addr[15:0] ^ 16'ha5c3;
			return colour_of({c.palsel[3:0], data[4 * (x % 4) +: 4]});
		end
		return colour_of(c.border);
	endfunction

	task automatic check_rgb(input string name, input tsvid_pkg::rgb_t exp,
		input tsvid_pkg::rgb_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input tsvid_pkg::dram_rd_t exp,
		input tsvid_pkg::dram_rd_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected %h actual %h", name, exp.addr, act.addr);
		end
	endtask

	task automatic port_write(input logic [7:0] addr, input logic [7:0] data);
		port_we <= 1'b1;
		port_wr <= {addr, data};
	endtask

	task automatic drive_inputs(input int tc);
		int f;
		int q;
		f = tc / FRAME;
		q = tc % FRAME;
		port_we <= 1'b0;
		cram_we <= 1'b0;
		// palette load right after reset
		if (tc >= 1 && tc <= 256) begin
			cram_we <= 1'b1;
			cram_wr <= {8'(tc - 1), pal_entry(8'(tc - 1))};
		end
		if (f < N_TESTS && q == WR_POS)
			port_write(tsvid_pkg::REG_VPAGE, tests[f].vpage);
		if (f < N_TESTS && q == WR_POS + 1)
			port_write(tsvid_pkg::REG_PALSEL, tests[f].palsel);
		// live registers change during vsync of the frame they apply to
		if (f >= 1 && f <= N_TESTS) begin
			case (q)
				10: port_write(tsvid_pkg::REG_BORDER, tests[f - 1].border);
				11: port_write(tsvid_pkg::REG_GY_OFFS, tests[f - 1].gy_offs);
				12: port_write(tsvid_pkg::REG_VINT_BEG, {2'b00, tests[f - 1].vint_beg});
				default: ;
			endcase
		end
	endtask

	task automatic check_cycle(input int tc);
		tsvid_pkg::vid_cfg_t c;
		string               tag;
		int                  p;
		int                  f;
		int                  h;
		int                  v;
		// video outputs lag the raster by the render pipe
		p = tc - tsvid_pkg::PIPE_LAT;
		f = p / FRAME;
		if (f >= 1 && f <= N_TESTS) begin
			h   = p % tsvid_pkg::H_TOTAL;
			v   = (p / tsvid_pkg::H_TOTAL) % tsvid_pkg::V_TOTAL;
			tag = $sformatf("cfg_%0d v%0d h%0d", f - 1, v, h);
			check_bit({tag, " hsync"}, h < tsvid_pkg::H_SYNC, hsync);
			check_bit({tag, " vsync"}, v < tsvid_pkg::V_SYNC, vsync);
			check_rgb({tag, " rgb"}, pixel_of(p), rgb);
		end
		f = tc / FRAME;
		h = tc % tsvid_pkg::H_TOTAL;
		v = (tc / tsvid_pkg::H_TOTAL) % tsvid_pkg::V_TOTAL;
		if (f >= 1 && f <= N_TESTS) begin
			// line 0 still follows the interrupt line of the previous frame
			c   = (v == 0) ? cfg_of(f - 1) : cfg_of(f);
			tag = $sformatf("cfg_%0d v%0d h%0d int_start", f - 1, v, h);
			check_bit(tag, h == 0 && v == c.vint_beg, int_start);
			if (int_start === 1'b1 && v >= 1)
				pulses++;
		end
	endtask

	task automatic report_test(input int f);
		int n;
		if (req_total != REQS * (f + 1)) begin
			err_cnt++;
			$display("[ERROR] cfg_%0d requests so far expected %0d actual %0d",
				f - 1, REQS * (f + 1), req_total);
		end
		if (pulses != 1) begin
			err_cnt++;
			$display("[ERROR] cfg_%0d int_start pulses expected 1 actual %0d", f - 1, pulses);
		end
		n = err_cnt - err_mark;
		if (n != 0)
			fails++;
		$display("test cfg_%0d: %s, %0d errors", f - 1, (n == 0) ? "passed" : "failed", n);
		pulses   = 0;
		err_mark = err_cnt;
	endtask

	// DRAM model, in-order responses after 1 to 8 cycles
	always @(posedge clk) begin
		mcyc++;
		dram_resp_valid <= 1'b0;
		dram_credit     <= 1'b0;
		if (q_due.size() > 0 && q_due[0] <= mcyc) begin
			rsp_addr        = q_addr.pop_front();
			void'(q_due.pop_front());
			dram_resp_valid <= 1'b1;
			dram_resp       <= rsp_addr[15:0] ^ 16'ha5c3;
			dram_credit     <= 1'b1;
		end
		if (!rst && dram_req_valid === 1'b1) begin
			lat = 0;
			repeat (3) begin
				lfsr = lfsr_step(lfsr);
				lat  = lat * 2 + lfsr[0];
			end
			q_addr.push_back(dram_req.addr);
			q_due.push_back(mcyc + lat + 1);
			if (q_addr.size() > tsvid_pkg::DRAM_CREDITS) begin
				err_cnt++;
				$display("more than %0d DRAM requests outstanding", tsvid_pkg::DRAM_CREDITS);
			end
			check_addr($sformatf("frame %0d request %0d", req_total / REQS, req_total % REQS),
				addr_of(req_total / REQS, (req_total % REQS) / tsvid_pkg::WORDS_PER_LINE,
				req_total % tsvid_pkg::WORDS_PER_LINE), dram_req);
			req_total++;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not end within %0d cycles", LIMIT);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		rst             = 1'b1;
		port_we         = 1'b0;
		port_wr         = '0;
		cram_we         = 1'b0;
		cram_wr         = '0;
		dram_resp_valid = 1'b0;
		dram_resp       = '0;
		dram_credit     = 1'b0;
		err_cnt         = 0;
		err_mark        = 0;
		fails           = 0;
		req_total       = 0;
		pulses          = 0;
		mcyc            = 0;
		t               = 0;
		lfsr            = 32'hce47ab2c;
		// border, vpage, gy_offs, palsel, vint_beg
		tests[0] = {8'h21, 8'h03, 8'h00, 8'h05, 6'd10};
		tests[1] = {8'h9c, 8'h1a, 8'hfa, 8'h0b, 6'd24};
		tests[2] = {8'h47, 8'hc5, 8'h37, 8'hf2, 6'd1};
		tests[3] = {8'hff, 8'h80, 8'h81, 8'h3e, 6'd39};
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		// t counts clocks from the edge where reset is released
		while (t < (N_TESTS + 1) * FRAME + 1) begin
			@(posedge clk);
			t++;
			drive_inputs(t);
			@(negedge clk);
			check_cycle(t);
			if (t % FRAME == 1 && t / FRAME >= 2)
				report_test(t / FRAME - 1);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			N_TESTS, N_TESTS - fails, fails, err_cnt);
		if (err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tsvid.f
design/tsvid_pkg.sv
design/video_ports.sv
design/video_sync.sv
design/video_fetch.sv
design/video_render.sv
design/video_top.sv
tests/tb_video_top.sv

// File: Bender.yml
package:
  name: tsvid

sources:
  - design/tsvid_pkg.sv
  - design/video_ports.sv
  - design/video_sync.sv
  - design/video_fetch.sv
  - design/video_render.sv
  - design/video_top.sv
  - target: test
    files:
      - tests/tb_video_top.sv
